//--- Makefile
# Verilator build of the option decoder and its testbench

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_frame_opts
RTL_TOP   ?= frame_opts_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- frame_cfg_merge.sv
// --------------------------------------------------------------------------
// merge of video and system configuration, final rotation, change strobe
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_cfg_merge (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  frame_opts_pkg::video_cfg_t video,
    input  frame_opts_pkg::sys_cfg_t   sys,
    output frame_opts_pkg::frame_cfg_t cfg,
    output logic                      cfg_update
);

    frame_opts_pkg::frame_cfg_t cfg_d;

    // decoder outputs are still the reset zeros in the first cycle
    logic dec_live;
    logic cfg_diff;

    always_comb begin
        cfg_d       = '0;
        cfg_d.video = video;
        cfg_d.sys   = sys;
        // upright unless flipped, rotate when tate
        cfg_d.rotate = {~sys.flip, video.tate};
    end

    assign cfg_diff = (cfg_d != cfg);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_live <= 1'b0;
        end else begin
            dec_live <= 1'b1;
        end
    end

    // new value loads and strobes together
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg        <= '0;
            cfg_update <= 1'b0;
        end else if (dec_live) begin
            cfg        <= cfg_d;
            cfg_update <= cfg_diff;
        end else begin
            cfg_update <= 1'b0;
        end
    end

    // back to back strobes need back to back changes
    a_upd_twice : assert property (
        @(posedge clk) disable iff (!arst_n)
        (cfg_update && $past(cfg_update)) |-> (cfg != $past(cfg))
    ) else $error("cfg_update held without a new cfg");

    // no silent change of the held configuration
    a_cfg_stable : assert property (
        @(posedge clk) disable iff (!arst_n)
        !cfg_update |-> $stable(cfg)
    ) else $error("cfg changed without cfg_update");

endmodule

`default_nettype wire

//--- frame_opts_pkg.sv
// --------------------------------------------------------------------------
// option word bit map, aspect defaults, mode and effects enums and the
// video, system and frame configuration structs
// --------------------------------------------------------------------------
`default_nettype none

package frame_opts_pkg;

    // option word from the on-screen menu
    localparam int status_w = 32;

    // bit positions inside the option word
    // flip is active high on this layout
    localparam int st_flip      = 1;
    // set to keep vertical games unrotated
    localparam int st_no_rotate = 2;
    // two-bit video mode field, bits 3 and 4
    localparam int st_vmode_lo  = 3;
    // two-bit effects volume field, bits 6 and 7
    localparam int st_fx_lo     = 6;
    // sound chip disables
    localparam int st_psg_off   = 8;
    localparam int st_fm_off    = 9;
    // service / test switch from the menu
    localparam int st_test      = 10;
    // pause requested while the menu is open
    localparam int st_osd_pause = 12;
    // two-bit aspect ratio field, bits 14 and 15
    localparam int st_ar_lo     = 14;

    // aspect ratio values for the HDMI scaler
    localparam int ar_w = 12;

    // native ratio of most arcade monitors
    localparam logic [ar_w-1:0] arx_default = 12'd4;
    localparam logic [ar_w-1:0] ary_default = 12'd3;

    // effects field is stored so that a cleared menu means high volume
    localparam logic [1:0] fx_base = 2'b10;

    // video filter modes, encoded as the raw menu field
    typedef enum logic [1:0] {
        vm_pass_thru     = 2'd0,
        vm_linear        = 2'd1,
        vm_analogue      = 2'd2,
        vm_analogue_scan = 2'd3
    } video_mode_e;

    // effects level after the xor with fx_base
    typedef enum logic [1:0] {
        fx_very_low  = 2'd0,
        fx_low       = 2'd1,
        fx_high      = 2'd2,
        fx_very_high = 2'd3
    } fx_level_e;

    // video side of the frame configuration
    typedef struct packed {
        video_mode_e     mode;
        logic [2:0]      scanlines;
        logic            bw_en;
        logic            blend_en;
        // mixing disabled for the odd video modes
        logic            en_mixing;
        // screen is vertical on the output
        logic            tate;
        logic [ar_w-1:0] hdmi_arx;
        logic [ar_w-1:0] hdmi_ary;
    } video_cfg_t;

    // system side of the frame configuration
    typedef struct packed {
        logic      enable_fm;
        logic      enable_psg;
        fx_level_e fx_level;
        // dip switches are active low
        logic      dip_test;
        logic      dip_pause;
        logic      osd_pause;
        logic      flip;
    } sys_cfg_t;

    // everything the core sees, plus the final rotation
    typedef struct packed {
        video_cfg_t video;
        sys_cfg_t   sys;
        // bit 1 = not flipped, bit 0 = rotate for tate
        logic [1:0] rotate;
    } frame_cfg_t;

endpackage

`default_nettype wire

//--- frame_opts_top.sv
// --------------------------------------------------------------------------
// option word decoding top, two decoders feeding the merge stage
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_opts_top (
    input  wire logic                                clk,
    input  wire logic                                arst_n,
    input  wire logic [frame_opts_pkg::status_w-1:0] status,
    input  wire logic                                vertical_game,
    input  wire logic                                key_test,
    input  wire logic                                game_pause,
    output frame_opts_pkg::frame_cfg_t               cfg,
    output logic                                     cfg_update
);

    // decoder to merge links
    frame_opts_pkg::video_cfg_t video;
    frame_opts_pkg::sys_cfg_t   sys;

    // both decoders sample the same option word
    video_opt_decode i_video_opt_decode (
        .clk           (clk),
        .arst_n        (arst_n),
        .status        (status),
        .vertical_game (vertical_game),
        .video         (video)
    );

    sys_opt_decode i_sys_opt_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .status     (status),
        .key_test   (key_test),
        .game_pause (game_pause),
        .sys        (sys)
    );

    // second pipeline stage
    frame_cfg_merge i_frame_cfg_merge (
        .clk        (clk),
        .arst_n     (arst_n),
        .video      (video),
        .sys        (sys),
        .cfg        (cfg),
        .cfg_update (cfg_update)
    );

endmodule

`default_nettype wire

//--- sys_opt_decode.sv
// --------------------------------------------------------------------------
// system option decoder, sound enables, effects, test, pause and flip
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sys_opt_decode (
    input  wire logic                                clk,
    input  wire logic                                arst_n,
    input  wire logic [frame_opts_pkg::status_w-1:0] status,
    input  wire logic                                key_test,
    input  wire logic                                game_pause,
    output frame_opts_pkg::sys_cfg_t                 sys
);

    frame_opts_pkg::sys_cfg_t sys_d;

    // effects field straight from the menu
    logic [1:0] fx_field;

    assign fx_field = status[frame_opts_pkg::st_fx_lo +: 2];

    always_comb begin
        sys_d = '0;

        // menu stores the sound chips as off bits
        sys_d.enable_fm  = ~status[frame_opts_pkg::st_fm_off];
        sys_d.enable_psg = ~status[frame_opts_pkg::st_psg_off];

        // cleared field maps to high volume
        sys_d.fx_level = frame_opts_pkg::fx_level_e'(fx_field ^ frame_opts_pkg::fx_base);

        // test from menu or the service key, active low dip
        sys_d.dip_test = ~(status[frame_opts_pkg::st_test] | key_test);

        // pause dip is active low too
        sys_d.dip_pause = ~game_pause;

        // menu pause and flip pass through as levels
        sys_d.osd_pause = status[frame_opts_pkg::st_osd_pause];
        sys_d.flip      = status[frame_opts_pkg::st_flip];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sys <= '0;
        end else begin
            sys <= sys_d;
        end
    end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// --------------------------------------------------------------------------
// testbench clock, 40 ns period, and active low reset for 3 cycles
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 3;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_frame_opts.sv
// --------------------------------------------------------------------------
// directed and random tests of the option decoding, reference model,
// compare tasks and cycle watchdog
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_frame_opts;

    localparam int drive_dly  = 5;
    localparam int max_cycles = 2000;
    localparam int n_random   = 200;

    logic                                clk;
    logic                                arst_n;
    logic [frame_opts_pkg::status_w-1:0] status;
    logic                                vertical_game;
    logic                                key_test;
    logic                                game_pause;
    frame_opts_pkg::frame_cfg_t          cfg;
    logic                                cfg_update;

    // value the DUT should be holding on cfg
    frame_opts_pkg::frame_cfg_t held_cfg;
    int                         cycles = 0;
    integer                     seed;

    tb_clk_gen i_tb_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    frame_opts_top i_frame_opts_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .status        (status),
        .vertical_game (vertical_game),
        .key_test      (key_test),
        .game_pause    (game_pause),
        .cfg           (cfg),
        .cfg_update    (cfg_update)
    );

    // reference decode from the option word rules
    function automatic frame_opts_pkg::frame_cfg_t expected_cfg(
        input logic [frame_opts_pkg::status_w-1:0] st,
        input logic vg,
        input logic kt,
        input logic gp
    );
        frame_opts_pkg::frame_cfg_t  e;
        logic [1:0]                  vm;
        logic [frame_opts_pkg::ar_w-1:0] ar_ext;
        e      = '0;
        vm     = st[frame_opts_pkg::st_vmode_lo +: 2];
        ar_ext = {{(frame_opts_pkg::ar_w-2){1'b0}}, st[frame_opts_pkg::st_ar_lo +: 2]};
        case (vm)
            2'd0:    e.video.mode = frame_opts_pkg::vm_pass_thru;
            2'd1:    e.video.mode = frame_opts_pkg::vm_linear;
            2'd2:    e.video.mode = frame_opts_pkg::vm_analogue;
            default: e.video.mode = frame_opts_pkg::vm_analogue_scan;
        endcase
        // mode table as columns
        e.video.scanlines = (vm == 2'd3) ? 3'd1 : 3'd0;
        e.video.bw_en     = vm[1];
        e.video.blend_en  = (vm != 2'd0);
        e.video.en_mixing = !vm[0];
        e.video.tate      = vg && !st[frame_opts_pkg::st_no_rotate];
        if (ar_ext == '0) begin
            e.video.hdmi_arx = e.video.tate ? 12'd3 : 12'd4;
            e.video.hdmi_ary = e.video.tate ? 12'd4 : 12'd3;
        end else begin
            e.video.hdmi_arx = ar_ext - 12'd1;
        end
        e.sys.enable_fm  = !st[frame_opts_pkg::st_fm_off];
        e.sys.enable_psg = !st[frame_opts_pkg::st_psg_off];
        // effects field xor 2'b10
        case (st[frame_opts_pkg::st_fx_lo +: 2])
            2'd0:    e.sys.fx_level = frame_opts_pkg::fx_high;
            2'd1:    e.sys.fx_level = frame_opts_pkg::fx_very_high;
            2'd2:    e.sys.fx_level = frame_opts_pkg::fx_very_low;
            default: e.sys.fx_level = frame_opts_pkg::fx_low;
        endcase
        e.sys.dip_test  = !(st[frame_opts_pkg::st_test] || kt);
        e.sys.dip_pause = !gp;
        e.sys.osd_pause = st[frame_opts_pkg::st_osd_pause];
        e.sys.flip      = st[frame_opts_pkg::st_flip];
        e.rotate        = {!e.sys.flip, e.video.tate};
        return e;
    endfunction

    function automatic logic [frame_opts_pkg::status_w-1:0] bit_at(input int pos);
        logic [frame_opts_pkg::status_w-1:0] w;
        w      = '0;
        w[pos] = 1'b1;
        return w;
    endfunction

    function automatic logic [frame_opts_pkg::status_w-1:0] field_at(
        input int         lo,
        input logic [1:0] v
    );
        logic [frame_opts_pkg::status_w-1:0] w;
        w         = '0;
        w[lo +: 2] = v;
        return w;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_video(input frame_opts_pkg::video_cfg_t got,
                               input frame_opts_pkg::video_cfg_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: video %s, got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_sys(input frame_opts_pkg::sys_cfg_t got,
                             input frame_opts_pkg::sys_cfg_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: sys %s, got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_rotate(input logic [1:0] got, input logic [1:0] exp,
                                input string what);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: rotate %s, got %b expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_update(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: cfg_update %s, got %b expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic compare_all(input frame_opts_pkg::frame_cfg_t exp, input logic exp_upd,
                               input string what);
        check_video(cfg.video, exp.video, what);
        check_sys(cfg.sys, exp.sys, what);
        check_rotate(cfg.rotate, exp.rotate, what);
        check_update(cfg_update, exp_upd, what);
    endtask

    // every drive and check sits just after a rising edge
    task automatic step_cycle();
        @(posedge clk);
        #drive_dly;
    endtask

    task automatic drive_inputs(input logic [frame_opts_pkg::status_w-1:0] st,
                                input logic vg, input logic kt, input logic gp);
        status        = st;
        vertical_game = vg;
        key_test      = kt;
        game_pause    = gp;
    endtask

    // one item through both stages with cfg unchanged in between
    task automatic apply_and_check(input logic [frame_opts_pkg::status_w-1:0] st,
                                   input logic vg, input logic kt, input logic gp);
        frame_opts_pkg::frame_cfg_t exp;
        logic                       exp_upd;
        exp     = expected_cfg(st, vg, kt, gp);
        exp_upd = (exp != held_cfg);
        drive_inputs(st, vg, kt, gp);
        step_cycle();
        compare_all(held_cfg, 1'b0, "in decoder stage");
        step_cycle();
        compare_all(exp, exp_upd, $sformatf("for status %h", st));
        held_cfg = exp;
    endtask

    task automatic after_reset();
        step_cycle();
        // decoders loaded and merge still at reset value
        compare_all('0, 1'b0, "after reset");
        step_cycle();
        held_cfg = expected_cfg('0, 1'b0, 1'b0, 1'b0);
        compare_all(held_cfg, 1'b1, "first decoded value");
        step_cycle();
        check_update(cfg_update, 1'b0, "after first value");
    endtask

    task automatic video_mode_table();
        int m;
        for (m = 0; m < 4; m++) begin
            apply_and_check(field_at(frame_opts_pkg::st_vmode_lo, m[1:0]), 1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic aspect_and_rotation();
        int a;
        apply_and_check('0, 1'b0, 1'b0, 1'b0);
        // vertical game swaps to 3:4
        apply_and_check('0, 1'b1, 1'b0, 1'b0);
        apply_and_check(bit_at(frame_opts_pkg::st_no_rotate), 1'b1, 1'b0, 1'b0);
        apply_and_check(bit_at(frame_opts_pkg::st_flip), 1'b1, 1'b0, 1'b0);
        apply_and_check(bit_at(frame_opts_pkg::st_flip), 1'b0, 1'b0, 1'b0);
        for (a = 1; a < 4; a++) begin
            apply_and_check(field_at(frame_opts_pkg::st_ar_lo, a[1:0]), 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic system_fields();
        int f;
        apply_and_check(bit_at(frame_opts_pkg::st_psg_off), 1'b0, 1'b0, 1'b0);
        apply_and_check(bit_at(frame_opts_pkg::st_fm_off), 1'b0, 1'b0, 1'b0);
        apply_and_check(bit_at(frame_opts_pkg::st_fm_off) | bit_at(frame_opts_pkg::st_psg_off),
                        1'b0, 1'b0, 1'b0);
        for (f = 0; f < 4; f++) begin
            apply_and_check(field_at(frame_opts_pkg::st_fx_lo, f[1:0]), 1'b0, 1'b0, 1'b0);
        end
        // test from the menu bit then the key then both
        apply_and_check(bit_at(frame_opts_pkg::st_test), 1'b0, 1'b0, 1'b0);
        apply_and_check('0, 1'b0, 1'b1, 1'b0);
        apply_and_check(bit_at(frame_opts_pkg::st_test), 1'b0, 1'b1, 1'b0);
        apply_and_check('0, 1'b0, 1'b0, 1'b1);
        apply_and_check(bit_at(frame_opts_pkg::st_osd_pause), 1'b0, 1'b0, 1'b1);
    endtask

    task automatic update_strobe();
        logic [frame_opts_pkg::status_w-1:0] st;
        st = field_at(frame_opts_pkg::st_vmode_lo, 2'd2) | bit_at(frame_opts_pkg::st_flip);
        apply_and_check(st, 1'b0, 1'b0, 1'b0);
        // strobe is a single cycle
        step_cycle();
        check_update(cfg_update, 1'b0, "held past one cycle");
        apply_and_check(st, 1'b0, 1'b0, 1'b0);
        // bit 20 is not decoded so no strobe
        apply_and_check(st | bit_at(20), 1'b0, 1'b0, 1'b0);
        apply_and_check(st, 1'b1, 1'b0, 1'b0);
    endtask

    // new inputs every cycle with two items in flight
    task automatic random_stream();
        frame_opts_pkg::frame_cfg_t exp_q[$];
        frame_opts_pkg::frame_cfg_t exp;
        logic [31:0]                r;
        logic [frame_opts_pkg::status_w-1:0] st;
        int                         i;
        for (i = 0; i < n_random + 2; i++) begin
            if (i >= 2) begin
                exp = exp_q.pop_front();
                compare_all(exp, exp != held_cfg, $sformatf("random item %0d", i - 2));
                held_cfg = exp;
            end
            if (i < n_random) begin
                st = $random(seed);
                r  = $random(seed);
                drive_inputs(st, r[0], r[1], r[2]);
                exp_q.push_back(expected_cfg(st, r[0], r[1], r[2]));
            end
            step_cycle();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= max_cycles);
        fail_run($sformatf("timeout: tests still running after %0d cycles", max_cycles));
    end

    initial begin
        drive_inputs('0, 1'b0, 1'b0, 1'b0);
        held_cfg = '0;
        seed     = 33;
        @(posedge arst_n);
        after_reset();
        video_mode_table();
        aspect_and_rotation();
        system_fields();
        update_strobe();
        random_stream();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- video_opt_decode.sv
// --------------------------------------------------------------------------
// video option decoder, mode table, tate and aspect ratio selection
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module video_opt_decode (
    input  wire logic                                clk,
    input  wire logic                                arst_n,
    input  wire logic [frame_opts_pkg::status_w-1:0] status,
    input  wire logic                                vertical_game,
    output frame_opts_pkg::video_cfg_t               video
);

    // decoded value, registered below
    frame_opts_pkg::video_cfg_t video_d;

    // raw fields of the option word
    logic [1:0] vmode_field;
    logic [1:0] ar_field;
    logic       no_rotate;

    assign vmode_field = status[frame_opts_pkg::st_vmode_lo +: 2];
    assign ar_field    = status[frame_opts_pkg::st_ar_lo +: 2];
    assign no_rotate   = status[frame_opts_pkg::st_no_rotate];

    always_comb begin
        video_d      = '0;
        video_d.mode = frame_opts_pkg::video_mode_e'(vmode_field);

        // filter settings per video mode
        unique case (video_d.mode)
            frame_opts_pkg::vm_pass_thru: begin
                video_d.scanlines = 3'd0;
                video_d.bw_en     = 1'b0;
                video_d.blend_en  = 1'b0;
            end
            frame_opts_pkg::vm_linear: begin
                video_d.scanlines = 3'd0;
                video_d.bw_en     = 1'b0;
                video_d.blend_en  = 1'b1;
            end
            frame_opts_pkg::vm_analogue: begin
                video_d.scanlines = 3'd0;
                video_d.bw_en     = 1'b1;
                video_d.blend_en  = 1'b1;
            end
            frame_opts_pkg::vm_analogue_scan: begin
                video_d.scanlines = 3'd1;
                video_d.bw_en     = 1'b1;
                video_d.blend_en  = 1'b1;
            end
        endcase

        // odd modes turn the mixer off
        video_d.en_mixing = ~vmode_field[0];

        // vertical game shown rotated unless the menu says no
        video_d.tate = vertical_game & ~no_rotate;

        if (ar_field == 2'd0) begin
            // native ratio, swapped for a rotated screen
            if (video_d.tate) begin
                video_d.hdmi_arx = frame_opts_pkg::ary_default;
                video_d.hdmi_ary = frame_opts_pkg::arx_default;
            end else begin
                video_d.hdmi_arx = frame_opts_pkg::arx_default;
                video_d.hdmi_ary = frame_opts_pkg::ary_default;
            end
        end else begin
            // scaler preset selected by the field
            video_d.hdmi_arx = {{(frame_opts_pkg::ar_w-2){1'b0}}, ar_field - 2'd1};
            video_d.hdmi_ary = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            video <= '0;
        end else begin
            video <= video_d;
        end
    end

    // scanlines only come with the analogue + scan mode
    a_scan_mode : assert property (
        @(posedge clk) disable iff (!arst_n)
        (video.scanlines != 3'd0) |-> (video.mode == frame_opts_pkg::vm_analogue_scan)
    ) else $error("scanlines set outside analogue scan mode");

endmodule

`default_nettype wire

//--- vlog.f
frame_opts_pkg.sv
video_opt_decode.sv
sys_opt_decode.sv
frame_cfg_merge.sv
frame_opts_top.sv
tb_clk_gen.sv
tb_frame_opts.sv
